/* execute.f */
common/exec_pkg.sv
design/inst_decoder.sv
design/alu.sv
design/int_regfile.sv
design/branch_unit.sv
design/mem_access.sv
design/execute.sv
verif/execute_props.sv
verif/execute_tb.sv

/* Bender.yml */
package:
  name: execute

sources:
  - common/exec_pkg.sv
  - design/inst_decoder.sv
  - design/alu.sv
  - design/int_regfile.sv
  - design/branch_unit.sv
  - design/mem_access.sv
  - design/execute.sv
  - target: test
    files:
      - verif/execute_props.sv
      - verif/execute_tb.sv

/* verif/execute_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_tb import exec_pkg::*;;

   typedef struct packed {
      word_t      inst;
      word_t      pc;
      word_t      rd_data;
      word_t      exp_data;
      word_t      exp_addr;
      word_t      exp_new_pc;
      mem_width_t exp_width;
      logic       is_mem;
      logic       exp_change;
      logic       exp_invalid;
   } row_t;

   logic     i_clk = 1'b0;
   logic     i_rst;
   word_t    i_inst;
   logic     i_inst_valid;
   word_t    i_pc;
   mem_req_t o_mem_req;
   logic     o_wr_valid;
   logic     i_wr_ready;
   logic     o_rd_ready;
   logic     i_rd_valid;
   word_t    i_rd_data;
   logic     o_pc_change;
   word_t    o_new_pc;
   logic     o_finished;
   logic     o_invalid_inst;

   row_t   rows[$];
   string  names[$];
   string  cur_name;
   bit     row_ok;
   int     passed;
   int     failed;
   int     cycles;
   int     limit;
   integer seed;

   execute #(
      .REG_COUNT (32)
   ) UUT (.*);

   bind execute execute_props u_props (.*);

   always #2 i_clk = ~i_clk;

   // Instruction encoders take operands in assembler order
   function automatic word_t itype(input logic [6:0] op, input logic [2:0] f3,
                                   input reg_idx_t rd, input reg_idx_t rs1,
                                   input logic [11:0] imm);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic word_t rtype(input logic [2:0] f3, input logic [6:0] f7,
                                   input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
      return {f7, rs2, rs1, f3, rd, OP_REG};
   endfunction

   function automatic word_t stype(input logic [2:0] f3, input reg_idx_t rs1,
                                   input reg_idx_t rs2, input logic [11:0] imm);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
   endfunction

   function automatic word_t btype(input logic [2:0] f3, input reg_idx_t rs1,
                                   input reg_idx_t rs2, input logic [12:0] imm);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
   endfunction

   function automatic word_t utype(input logic [6:0] op, input reg_idx_t rd,
                                   input logic [19:0] imm);
      return {imm, rd, op};
   endfunction

   function automatic word_t jtype(input reg_idx_t rd, input logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
   endfunction

   task automatic push_row(input string name, input row_t r);
      rows.push_back(r);
      names.push_back(name);
   endtask

   task automatic alu_case(input string name, input word_t inst, input word_t pc);
      row_t r;
      r = '0;
      r.inst = inst;
      r.pc = pc;
      push_row(name, r);
   endtask

   task automatic flow_case(input string name, input word_t inst, input word_t pc,
                            input logic taken, input word_t target);
      row_t r;
      r = '0;
      r.inst = inst;
      r.pc = pc;
      r.exp_change = taken;
      r.exp_new_pc = target;
      push_row(name, r);
   endtask

   task automatic branch_case(input string name, input logic [2:0] f3, input reg_idx_t rs1,
                              input reg_idx_t rs2, input logic taken);
      flow_case(name, btype(f3, rs1, rs2, 13'h020), 32'h4000, taken, 32'h4020);
   endtask

   task automatic store_case(input string name, input word_t inst, input word_t addr,
                             input mem_width_t width, input word_t data);
      row_t r;
      r = '0;
      r.inst = inst;
      r.is_mem = 1'b1;
      r.exp_addr = addr;
      r.exp_width = width;
      r.exp_data = data;
      push_row(name, r);
   endtask

   // Register contents show up as store data
   task automatic reg_check(input string name, input reg_idx_t rs, input word_t exp);
      store_case(name, stype(F3_WORD, 0, rs, 12'h100), 32'h100, MEM_WORD, exp);
   endtask

   task automatic load_case(input string name, input word_t inst, input word_t rd_data,
                            input word_t addr, input mem_width_t width);
      row_t r;
      r = '0;
      r.inst = inst;
      r.is_mem = 1'b1;
      r.rd_data = rd_data;
      r.exp_addr = addr;
      r.exp_width = width;
      push_row(name, r);
   endtask

   task automatic bad_case(input string name, input word_t inst);
      row_t r;
      r = '0;
      r.inst = inst;
      r.exp_invalid = 1'b1;
      push_row(name, r);
   endtask

   // x1 = 5 and x2 = -7 serve as operands throughout
   task automatic build_table();
      alu_case("addi_pos", itype(OP_IMM, F3_ADD, 1, 0, 12'd5), 0);
      reg_check("sw_addi_pos", 1, 32'h0000_0005);
      alu_case("addi_neg", itype(OP_IMM, F3_ADD, 2, 0, 12'hFF9), 0);
      reg_check("sw_addi_neg", 2, 32'hFFFF_FFF9);
      alu_case("sub", rtype(F3_ADD, F7_ALT, 3, 1, 2), 0);
      reg_check("sw_sub", 3, 32'h0000_000C);
      alu_case("slt", rtype(F3_SLT, F7_BASE, 4, 2, 1), 0);
      reg_check("sw_slt", 4, 32'h0000_0001);
      alu_case("sltu", rtype(F3_SLTU, F7_BASE, 5, 1, 2), 0);
      reg_check("sw_sltu", 5, 32'h0000_0001);
      alu_case("xor", rtype(F3_XOR, F7_BASE, 6, 1, 2), 0);
      reg_check("sw_xor", 6, 32'hFFFF_FFFC);
      alu_case("or", rtype(F3_OR, F7_BASE, 7, 1, 2), 0);
      reg_check("sw_or", 7, 32'hFFFF_FFFD);
      alu_case("andi", itype(OP_IMM, F3_AND, 8, 2, 12'h0F0), 0);
      reg_check("sw_andi", 8, 32'h0000_00F0);
      alu_case("slli", itype(OP_IMM, F3_SLL, 9, 1, {F7_BASE, 5'd3}), 0);
      reg_check("sw_slli", 9, 32'h0000_0028);
      alu_case("srli", itype(OP_IMM, F3_SRL, 10, 2, {F7_BASE, 5'd4}), 0);
      reg_check("sw_srli", 10, 32'h0FFF_FFFF);
      alu_case("srai", itype(OP_IMM, F3_SRL, 11, 2, {F7_ALT, 5'd1}), 0);
      reg_check("sw_srai", 11, 32'hFFFF_FFFC);
      alu_case("sra", rtype(F3_SRL, F7_ALT, 12, 2, 1), 0);
      reg_check("sw_sra", 12, 32'hFFFF_FFFF);
      alu_case("lui", utype(LUI, 13, 20'hABCDE), 0);
      reg_check("sw_lui", 13, 32'hABCD_E000);
      alu_case("auipc", utype(AUIPC, 14, 20'h00012), 32'h1000);
      reg_check("sw_auipc", 14, 32'h0001_3000);
      flow_case("jal", jtype(15, 21'h00040), 32'h2000, 1'b1, 32'h2040);
      reg_check("sw_jal_link", 15, 32'h0000_2004);
      // Target 0x15 loses bit 0
      flow_case("jalr", itype(JALR, 3'b000, 16, 1, 12'h010), 32'h3000, 1'b1, 32'h14);
      reg_check("sw_jalr_link", 16, 32'h0000_3004);
      alu_case("addi_x0", itype(OP_IMM, F3_ADD, 0, 0, 12'h055), 0);
      reg_check("sw_x0", 0, 32'h0000_0000);
      store_case("sb", stype(F3_BYTE, 1, 6, 12'd3), 32'h8, MEM_BYTE, 32'hFFFF_FFFC);
      store_case("sh", stype(F3_HALF, 9, 7, 12'hFFE), 32'h26, MEM_HALF, 32'hFFFF_FFFD);
      load_case("lb", itype(LOAD, F3_BYTE, 17, 9, 12'd0), 32'h0000_0080, 32'h28, MEM_BYTE);
      reg_check("sw_lb", 17, 32'hFFFF_FF80);
      load_case("lbu", itype(LOAD, F3_BYTE_U, 18, 9, 12'd1), 32'h1234_5680, 32'h29, MEM_BYTE);
      reg_check("sw_lbu", 18, 32'h0000_0080);
      load_case("lh", itype(LOAD, F3_HALF, 19, 9, 12'd2), 32'h0000_8001, 32'h2A, MEM_HALF);
      reg_check("sw_lh", 19, 32'hFFFF_8001);
      load_case("lhu", itype(LOAD, F3_HALF_U, 20, 9, 12'hFFC), 32'hFFFF_8001, 32'h24, MEM_HALF);
      reg_check("sw_lhu", 20, 32'h0000_8001);
      load_case("lw", itype(LOAD, F3_WORD, 21, 9, 12'h010), 32'hDEAD_BEEF, 32'h38, MEM_WORD);
      reg_check("sw_lw", 21, 32'hDEAD_BEEF);
      branch_case("beq_taken", F3_BEQ, 1, 1, 1'b1);
      branch_case("beq_not", F3_BEQ, 1, 2, 1'b0);
      branch_case("bne_taken", F3_BNE, 1, 2, 1'b1);
      branch_case("bne_not", F3_BNE, 1, 1, 1'b0);
      branch_case("blt_taken", F3_BLT, 2, 1, 1'b1);
      branch_case("blt_not", F3_BLT, 1, 2, 1'b0);
      branch_case("bge_equal", F3_BGE, 1, 1, 1'b1);
      branch_case("bge_taken", F3_BGE, 1, 2, 1'b1);
      branch_case("bge_not", F3_BGE, 2, 1, 1'b0);
      branch_case("bltu_taken", F3_BLTU, 1, 2, 1'b1);
      branch_case("bltu_not", F3_BLTU, 2, 1, 1'b0);
      branch_case("bgeu_equal", F3_BGEU, 1, 1, 1'b1);
      branch_case("bgeu_taken", F3_BGEU, 2, 1, 1'b1);
      branch_case("bgeu_not", F3_BGEU, 1, 2, 1'b0);
      flow_case("beq_back", btype(F3_BEQ, 0, 0, 13'h1FF8), 32'h4000, 1'b1, 32'h3FF8);
      bad_case("bad_opcode", 32'h0000_007F);
      bad_case("bad_srl_f7", rtype(F3_SRL, 7'b0000001, 22, 1, 2));
      bad_case("bad_sub_f7", rtype(F3_ADD, 7'b0100001, 22, 1, 2));
   endtask

   task automatic check_word(input string what, input word_t exp, input word_t act);
      assert (act === exp) else begin
         $display("** Error %s %s: expected %h, actual %h", cur_name, what, exp, act);
         row_ok = 1'b0;
      end
   endtask

   task automatic report_test();
      $display("%-14s %s", cur_name, row_ok ? "passed" : "FAILED");
      if (row_ok) begin
         passed++;
      end else begin
         failed++;
      end
   endtask

   task automatic check_idle();
      cur_name = "idle_strobes";
      row_ok = 1'b1;
      i_inst = stype(F3_WORD, 0, 1, 12'h100);
      repeat (3) begin
         @(negedge i_clk);
         assert (!(o_wr_valid || o_rd_ready || o_pc_change || o_finished || o_invalid_inst))
         else begin
            $display("%s: a strobe was high while i_inst_valid was low", cur_name);
            row_ok = 1'b0;
         end
      end
      report_test();
   endtask

   // Stores request a write and loads a read, nothing else touches memory
   task automatic check_strobes(input row_t r);
      check_word("o_wr_valid", 32'(r.is_mem && r.inst[6:0] == STORE), 32'(o_wr_valid));
      check_word("o_rd_ready", 32'(r.is_mem && r.inst[6:0] == LOAD), 32'(o_rd_ready));
   endtask

   task automatic check_outputs(input row_t r);
      check_strobes(r);
      check_word("o_invalid_inst", 32'(r.exp_invalid), 32'(o_invalid_inst));
      check_word("o_pc_change", 32'(r.exp_change), 32'(o_pc_change));
      if (r.exp_change) begin
         check_word("o_new_pc", r.exp_new_pc, o_new_pc);
      end
      if (r.is_mem) begin
         check_word("address", r.exp_addr, o_mem_req.addr);
         check_word("width", 32'(r.exp_width), 32'(o_mem_req.width));
         if (r.inst[6:0] == STORE) begin
            check_word("write data", r.exp_data, o_mem_req.wdata);
         end
      end
   endtask

   task automatic run_row(input int idx);
      row_t r;
      int   delay;
      int   waited;
      bit   done;
      r = rows[idx];
      cur_name = names[idx];
      row_ok = 1'b1;
      delay = r.is_mem ? ($random(seed) & 3) : 0;
      waited = 0;
      done = 1'b0;
      @(posedge i_clk);
      #1;
      i_inst = r.inst;
      i_pc = r.pc;
      i_rd_data = r.rd_data;
      i_inst_valid = 1'b1;
      i_wr_ready = 1'b0;
      i_rd_valid = 1'b0;
      while (!done) begin
         // Memory answers after the random delay
         if (waited == delay) begin
            i_wr_ready = (r.inst[6:0] == STORE);
            i_rd_valid = (r.inst[6:0] == LOAD);
         end
         @(negedge i_clk);
         if (o_finished) begin
            assert (waited >= delay) else begin
               $display("%s: o_finished rose before the memory handshake", cur_name);
               row_ok = 1'b0;
            end
            check_outputs(r);
            done = 1'b1;
         end else begin
            // Request must stay up under back-pressure
            check_strobes(r);
            assert (waited < delay) else begin
               $display("%s: o_finished stayed low after the handshake", cur_name);
               row_ok = 1'b0;
               done = 1'b1;
            end
            if (!done) begin
               @(posedge i_clk);
               #1;
               waited++;
            end
         end
      end
      report_test();
   endtask

   initial begin
      cycles = 0;
      while (limit == 0 || cycles < limit) begin
         @(posedge i_clk);
         cycles++;
      end
      $display("Timeout after %0d cycles, the DUT stopped finishing instructions", cycles);
      $display("Something failed");
      $finish;
   end

   initial begin
      i_rst = 1'b1;
      i_inst = '0;
      i_inst_valid = 1'b0;
      i_pc = '0;
      i_wr_ready = 1'b0;
      i_rd_valid = 1'b0;
      i_rd_data = '0;
      seed = 32'h7fef_c1fb;
      passed = 0;
      failed = 0;
      limit = 0;
      build_table();
      limit = rows.size() * 6 + 20;
      repeat (2) @(posedge i_clk);
      #1;
      i_rst = 1'b0;
      check_idle();
      foreach (rows[k]) begin
         run_row(k);
      end
      $display("Tests: %0d passed, %0d failed", passed, failed);
      if (failed == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verif/execute_props.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_props import exec_pkg::*; (
   input logic     i_clk,
   input logic     i_rst,
   input word_t    i_inst,
   input logic     i_inst_valid,
   input mem_req_t o_mem_req,
   input logic     o_wr_valid,
   input logic     i_wr_ready,
   input logic     o_rd_ready,
   input logic     i_rd_valid,
   input logic     o_pc_change,
   input logic     o_finished,
   input logic     o_invalid_inst
);

   logic mem_opcode;

   assign mem_opcode = (i_inst[6:0] == LOAD) || (i_inst[6:0] == STORE);

   // Store request holds until memory takes it
   store_held: assert property (@(posedge i_clk) disable iff (i_rst)
      o_wr_valid && !i_wr_ready |=> o_wr_valid && $stable(o_mem_req))
      else $error("store request dropped or changed before i_wr_ready");

   idle_quiet: assert property (@(posedge i_clk) disable iff (i_rst)
      !i_inst_valid |-> !(o_wr_valid || o_rd_ready || o_pc_change || o_finished ||
                          o_invalid_inst))
      else $error("strobe high while i_inst_valid is low");

   mem_finish: assert property (@(posedge i_clk) disable iff (i_rst)
      o_finished && mem_opcode && !o_invalid_inst |->
         (o_wr_valid && i_wr_ready) || (o_rd_ready && i_rd_valid))
      else $error("memory instruction finished without a transfer");

endmodule

`default_nettype wire

/* design/execute.sv */
`timescale 1ns/10ps
`default_nettype none

module execute import exec_pkg::*; #(
   parameter int REG_COUNT = 32
) (
   input  logic     i_clk,
   input  logic     i_rst,

   input  word_t    i_inst,
   input  logic     i_inst_valid,
   input  word_t    i_pc,

   output mem_req_t o_mem_req,
   output logic     o_wr_valid,
   input  logic     i_wr_ready,
   output logic     o_rd_ready,
   input  logic     i_rd_valid,
   input  word_t    i_rd_data,

   output logic     o_pc_change,
   output word_t    o_new_pc,
   output logic     o_finished,
   output logic     o_invalid_inst
);

   dec_inst_t dec;
   alu_op_t   alu_op;
   word_t     alu_a;
   word_t     alu_b;
   word_t     alu_result;
   logic      dec_invalid;
   word_t     rs1_data;
   word_t     rs2_data;
   logic      pc_change;
   logic      wr_valid;
   logic      rd_ready;
   logic      mem_done;
   word_t     load_data;
   logic      mem_op;
   logic      has_rd;
   logic      rf_we;
   word_t     wb_data;

   inst_decoder #(
      .REG_COUNT (REG_COUNT)
   ) u_decoder (
      .i_inst     (i_inst),
      .i_pc       (i_pc),
      .i_rs1_data (rs1_data),
      .i_rs2_data (rs2_data),
      .o_dec      (dec),
      .o_alu_op   (alu_op),
      .o_alu_a    (alu_a),
      .o_alu_b    (alu_b),
      .o_invalid  (dec_invalid)
   );

   int_regfile #(
      .REG_COUNT (REG_COUNT)
   ) u_regfile (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_rs1      (dec.rs1),
      .i_rs2      (dec.rs2),
      .o_rs1_data (rs1_data),
      .o_rs2_data (rs2_data),
      .i_we       (rf_we),
      .i_rd       (dec.rd),
      .i_wdata    (wb_data)
   );

   alu u_alu (
      .i_op     (alu_op),
      .i_a      (alu_a),
      .i_b      (alu_b),
      .o_result (alu_result)
   );

   branch_unit u_branch (
      .i_dec       (dec),
      .i_rs1_data  (rs1_data),
      .i_rs2_data  (rs2_data),
      .i_target    (alu_result),
      .o_pc_change (pc_change),
      .o_new_pc    (o_new_pc)
   );

   mem_access u_mem (
      .i_dec        (dec),
      .i_addr       (alu_result),
      .i_store_data (rs2_data),
      .i_wr_ready   (i_wr_ready),
      .i_rd_valid   (i_rd_valid),
      .i_rd_data    (i_rd_data),
      .o_req        (o_mem_req),
      .o_wr_valid   (wr_valid),
      .o_rd_ready   (rd_ready),
      .o_done       (mem_done),
      .o_load_data  (load_data)
   );

   // Invalid loads and stores never reach memory
   assign mem_op = (dec.opcode inside {LOAD, STORE}) && !dec_invalid;

   assign o_wr_valid     = i_inst_valid && mem_op && wr_valid;
   assign o_rd_ready     = i_inst_valid && mem_op && rd_ready;
   assign o_pc_change    = i_inst_valid && !dec_invalid && pc_change;
   assign o_invalid_inst = i_inst_valid && dec_invalid;
   assign o_finished     = i_inst_valid && (mem_op ? mem_done : 1'b1);

   assign has_rd = (dec.opcode inside {LOAD, OP_IMM, OP_REG, LUI, AUIPC, JAL, JALR});
   assign rf_we  = o_finished && has_rd && !dec_invalid;

   always_comb begin
      case (dec.opcode)
         LUI:       wb_data = dec.imm_u;
         JAL, JALR: wb_data = i_pc + 32'd4;
         LOAD:      wb_data = load_data;
         default:   wb_data = alu_result;
      endcase
   end

endmodule

`default_nettype wire

/* design/mem_access.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_access import exec_pkg::*; (
   input  dec_inst_t i_dec,
   input  word_t     i_addr,
   input  word_t     i_store_data,
   input  logic      i_wr_ready,
   input  logic      i_rd_valid,
   input  word_t     i_rd_data,
   output mem_req_t  o_req,
   output logic      o_wr_valid,
   output logic      o_rd_ready,
   output logic      o_done,
   output word_t     o_load_data
);

   logic is_load;
   logic is_store;

   assign is_load  = (i_dec.opcode == LOAD);
   assign is_store = (i_dec.opcode == STORE);

   // Strobes follow the opcode and hold until the transfer
   assign o_wr_valid = is_store;
   assign o_rd_ready = is_load;
   assign o_done     = (is_store && i_wr_ready) || (is_load && i_rd_valid);

   always_comb begin
      o_req.addr  = i_addr;
      o_req.wdata = is_store ? i_store_data : '0;
      o_req.width = MEM_NONE;
      if (is_load || is_store) begin
         case (i_dec.funct3)
            F3_BYTE, F3_BYTE_U: o_req.width = MEM_BYTE;
            F3_HALF, F3_HALF_U: o_req.width = MEM_HALF;
            F3_WORD:            o_req.width = MEM_WORD;
            default:            o_req.width = MEM_NONE;
         endcase
      end
   end

   // Read data arrives in the low lanes
   always_comb begin
      case (i_dec.funct3)
         F3_BYTE:   o_load_data = {{24{i_rd_data[7]}}, i_rd_data[7:0]};
         F3_BYTE_U: o_load_data = {24'b0, i_rd_data[7:0]};
         F3_HALF:   o_load_data = {{16{i_rd_data[15]}}, i_rd_data[15:0]};
         F3_HALF_U: o_load_data = {16'b0, i_rd_data[15:0]};
         default:   o_load_data = i_rd_data;
      endcase
   end

endmodule

`default_nettype wire

/* design/branch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_unit import exec_pkg::*; (
   input  dec_inst_t i_dec,
   input  word_t     i_rs1_data,
   input  word_t     i_rs2_data,
   input  word_t     i_target,
   output logic      o_pc_change,
   output word_t     o_new_pc
);

   logic eq;
   logic lt_s;
   logic lt_u;
   logic taken;

   assign eq   = (i_rs1_data == i_rs2_data);
   assign lt_s = ($signed(i_rs1_data) < $signed(i_rs2_data));
   assign lt_u = (i_rs1_data < i_rs2_data);

   always_comb begin
      case (i_dec.funct3)
         F3_BEQ:  taken = eq;
         F3_BNE:  taken = !eq;
         F3_BLT:  taken = lt_s;
         F3_BGE:  taken = !lt_s;
         F3_BLTU: taken = lt_u;
         F3_BGEU: taken = !lt_u;
         default: taken = 1'b0;
      endcase
   end

   always_comb begin
      o_pc_change = 1'b0;
      o_new_pc    = i_target;
      case (i_dec.opcode)
         JAL: o_pc_change = 1'b1;
         JALR: begin
            o_pc_change = 1'b1;
            o_new_pc    = {i_target[31:1], 1'b0};
         end
         BRANCH: o_pc_change = taken;
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* design/int_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module int_regfile import exec_pkg::*; #(
   parameter int REG_COUNT = 32
) (
   input  logic     i_clk,
   input  logic     i_rst,
   input  reg_idx_t i_rs1,
   input  reg_idx_t i_rs2,
   output word_t    o_rs1_data,
   output word_t    o_rs2_data,
   input  logic     i_we,
   input  reg_idx_t i_rd,
   input  word_t    i_wdata
);

   word_t regs [REG_COUNT];

   // x0 and indices past the file read as zero
   assign o_rs1_data = (i_rs1 != '0 && i_rs1 < REG_COUNT) ? regs[i_rs1] : '0;
   assign o_rs2_data = (i_rs2 != '0 && i_rs2 < REG_COUNT) ? regs[i_rs2] : '0;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we && i_rd != '0 && i_rd < REG_COUNT) begin
         regs[i_rd] <= i_wdata;
      end
   end

endmodule

`default_nettype wire

/* design/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu import exec_pkg::*; (
   input  alu_op_t i_op,
   input  word_t   i_a,
   input  word_t   i_b,
   output word_t   o_result
);

   logic [4:0] shamt;

   assign shamt = i_b[4:0];

   always_comb begin
      case (i_op)
         ALU_ADD:  o_result = i_a + i_b;
         ALU_SUB:  o_result = i_a - i_b;
         ALU_SLT:  o_result = {31'b0, $signed(i_a) < $signed(i_b)};
         ALU_SLTU: o_result = {31'b0, i_a < i_b};
         ALU_AND:  o_result = i_a & i_b;
         ALU_OR:   o_result = i_a | i_b;
         ALU_XOR:  o_result = i_a ^ i_b;
         ALU_SLL:  o_result = i_a << shamt;
         ALU_SRL:  o_result = i_a >> shamt;
         // Arithmetic shift keeps the sign bit
         ALU_SRA:  o_result = word_t'($signed(i_a) >>> shamt);
         default:  o_result = '0;
      endcase
   end

endmodule

`default_nettype wire

/* design/inst_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module inst_decoder import exec_pkg::*; #(
   parameter int REG_COUNT = 32
) (
   input  word_t     i_inst,
   input  word_t     i_pc,
   input  word_t     i_rs1_data,
   input  word_t     i_rs2_data,
   output dec_inst_t o_dec,
   output alu_op_t   o_alu_op,
   output word_t     o_alu_a,
   output word_t     o_alu_b,
   output logic      o_invalid
);

   word_t imm_i;
   word_t imm_s;
   word_t imm_b;
   word_t imm_j;
   logic  uses_rd;
   logic  uses_rs1;
   logic  uses_rs2;
   logic  bad_enc;
   logic  bad_reg;

   assign o_dec.opcode = opcode_t'(i_inst[6:0]);
   assign o_dec.rd     = i_inst[11:7];
   assign o_dec.funct3 = i_inst[14:12];
   assign o_dec.rs1    = i_inst[19:15];
   assign o_dec.rs2    = i_inst[24:20];
   assign o_dec.funct7 = i_inst[31:25];
   assign o_dec.imm_u  = {i_inst[31:12], 12'b0};

   assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
   assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
   assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
   assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21],
                   1'b0};

   always_comb begin
      o_alu_op = ALU_ADD;
      o_alu_a  = i_rs1_data;
      o_alu_b  = imm_i;
      uses_rd  = 1'b0;
      uses_rs1 = 1'b0;
      uses_rs2 = 1'b0;
      bad_enc  = 1'b0;
      case (o_dec.opcode)
         LOAD: begin
            uses_rd  = 1'b1;
            uses_rs1 = 1'b1;
            bad_enc  = !(o_dec.funct3 inside {F3_BYTE, F3_HALF, F3_WORD, F3_BYTE_U, F3_HALF_U});
         end
         STORE: begin
            o_alu_b  = imm_s;
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
            bad_enc  = !(o_dec.funct3 inside {F3_BYTE, F3_HALF, F3_WORD});
         end
         BRANCH: begin
            o_alu_a  = i_pc;
            o_alu_b  = imm_b;
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
            bad_enc  = (o_dec.funct3 inside {3'b010, 3'b011});
         end
         JAL: begin
            o_alu_a = i_pc;
            o_alu_b = imm_j;
            uses_rd = 1'b1;
         end
         JALR: begin
            uses_rd  = 1'b1;
            uses_rs1 = 1'b1;
            bad_enc  = (o_dec.funct3 != 3'b000);
         end
         AUIPC: begin
            o_alu_a = i_pc;
            o_alu_b = o_dec.imm_u;
            uses_rd = 1'b1;
         end
         LUI: begin
            uses_rd = 1'b1;
         end
         OP_IMM, OP_REG: begin
            uses_rd  = 1'b1;
            uses_rs1 = 1'b1;
            uses_rs2 = (o_dec.opcode == OP_REG);
            if (o_dec.opcode == OP_REG) begin
               o_alu_b = i_rs2_data;
            end
            case (o_dec.funct3)
               F3_ADD: begin
                  // SUB exists only in the register form
                  if (o_dec.opcode == OP_REG && o_dec.funct7 == F7_ALT) begin
                     o_alu_op = ALU_SUB;
                  end else if (o_dec.opcode == OP_REG && o_dec.funct7 != F7_BASE) begin
                     bad_enc = 1'b1;
                  end
               end
               F3_SLL: begin
                  o_alu_op = ALU_SLL;
                  bad_enc  = (o_dec.funct7 != F7_BASE);
               end
               F3_SRL: begin
                  if (o_dec.funct7 == F7_ALT) begin
                     o_alu_op = ALU_SRA;
                  end else begin
                     o_alu_op = ALU_SRL;
                     bad_enc  = (o_dec.funct7 != F7_BASE);
                  end
               end
               default: begin
                  case (o_dec.funct3)
                     F3_SLT:  o_alu_op = ALU_SLT;
                     F3_SLTU: o_alu_op = ALU_SLTU;
                     F3_XOR:  o_alu_op = ALU_XOR;
                     F3_OR:   o_alu_op = ALU_OR;
                     default: o_alu_op = ALU_AND;
                  endcase
                  bad_enc = (o_dec.opcode == OP_REG) && (o_dec.funct7 != F7_BASE);
               end
            endcase
         end
         NOP: ;
         default: bad_enc = 1'b1;
      endcase
   end

   // Only fields that the format uses are range checked
   assign bad_reg = (uses_rd  && (o_dec.rd  >= REG_COUNT)) ||
                    (uses_rs1 && (o_dec.rs1 >= REG_COUNT)) ||
                    (uses_rs2 && (o_dec.rs2 >= REG_COUNT));

   assign o_invalid = bad_enc || bad_reg;

endmodule

`default_nettype wire

/* common/exec_pkg.sv */
`default_nettype none

package exec_pkg;

   // Data, address and program counter
   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;

   // RV32I major opcodes
   typedef enum logic [6:0] {
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011,
      OP_IMM = 7'b0010011,
      OP_REG = 7'b0110011,
      LUI    = 7'b0110111,
      AUIPC  = 7'b0010111,
      JAL    = 7'b1101111,
      JALR   = 7'b1100111,
      BRANCH = 7'b1100011,
      NOP    = 7'b0001111
   } opcode_t;

   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_SLT  = 4'd2,
      ALU_SLTU = 4'd3,
      ALU_AND  = 4'd4,
      ALU_OR   = 4'd5,
      ALU_XOR  = 4'd6,
      ALU_SLL  = 4'd7,
      ALU_SRL  = 4'd8,
      ALU_SRA  = 4'd9
   } alu_op_t;

   // Access size in bytes
   typedef enum logic [2:0] {
      MEM_NONE = 3'd0,
      MEM_BYTE = 3'd1,
      MEM_HALF = 3'd2,
      MEM_WORD = 3'd4
   } mem_width_t;

   typedef struct packed {
      opcode_t    opcode;
      reg_idx_t   rd;
      reg_idx_t   rs1;
      reg_idx_t   rs2;
      logic [2:0] funct3;
      logic [6:0] funct7;
      word_t      imm_u;
   } dec_inst_t;

   typedef struct packed {
      word_t      addr;
      word_t      wdata;
      mem_width_t width;
   } mem_req_t;

   // Load and store widths
   localparam logic [2:0] F3_BYTE   = 3'b000;
   localparam logic [2:0] F3_HALF   = 3'b001;
   localparam logic [2:0] F3_WORD   = 3'b010;
   localparam logic [2:0] F3_BYTE_U = 3'b100;
   localparam logic [2:0] F3_HALF_U = 3'b101;

   // Branch conditions
   localparam logic [2:0] F3_BEQ  = 3'b000;
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_BLT  = 3'b100;
   localparam logic [2:0] F3_BGE  = 3'b101;
   localparam logic [2:0] F3_BLTU = 3'b110;
   localparam logic [2:0] F3_BGEU = 3'b111;

   // Arithmetic and shifts
   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLL  = 3'b001;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_SRL  = 3'b101;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire
